/* rtl/bp_pkg.sv */
package bp_pkg;

    typedef logic [31:0] rv32i_word;       // pcs and targets
    typedef logic [9:0]  br_hist_t;        // bit 9 is the newest outcome
    typedef logic [11:0] bimm_t;           // branch imm[12:1]

    typedef enum logic [6:0] {
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_br    = 7'b1100011,             // conditional branch
        op_jal   = 7'b1101111,             // direct jump
        op_jalr  = 7'b1100111              // not predicted here
    } rv32i_opcode;

    // history thresholds of the prediction rule
    localparam br_hist_t HIST_TAKE_MIN  = 10'b1110000000; // at or above: taken
    localparam br_hist_t HIST_NOT_MIN   = 10'b0000010000; // below: not taken
    localparam br_hist_t HIST_ACC_LIMIT = 10'b1101010000; // xor at or above: flip
    localparam br_hist_t HIST_RESET     = 10'b1000000000; // one taken seen

    localparam rv32i_word NO_TARGET = 32'hff;   // target reported on a miss

    typedef struct packed {
        rv32i_word   pc;
        rv32i_opcode opcode;
        logic        taken;         // outcome computed in execute
        rv32i_word   jump_target;   // jal destination
        bimm_t       bimm;
        logic        predicted;     // direction guessed at fetch
        rv32i_word   pred_target;   // target guessed at fetch
    } exe_info_t;

    typedef struct packed {
        logic      prediction;
        rv32i_word target;
    } fetch_pred_t;

endpackage : bp_pkg

/* rtl/btb_entry.sv */
`timescale 1ns/10ps

module btb_entry (
    input  logic             clk,
    input  logic             rst,
    input  logic             update_pc,        // allocate this entry
    input  logic             update_history,   // shift in a resolved outcome
    input  logic             taken,
    input  logic             predicted,        // prediction carried with the instr
    input  bp_pkg::rv32i_word pc_exe,
    input  bp_pkg::rv32i_word pc_fetch,
    input  bp_pkg::bimm_t     target_offset,
    output logic             fetch_hit,
    output logic             exe_hit,
    output logic             branch_prediction,
    output bp_pkg::rv32i_word branch_target
);
    import bp_pkg::*;

    logic      valid;
    rv32i_word instr_pc;        // pc of the cached branch
    bimm_t     offset;
    br_hist_t  taken_hist;      // actual outcomes, newest in bit 9
    br_hist_t  pred_hist;       // predictions made, same order

    assign fetch_hit = valid && (pc_fetch == instr_pc);
    assign exe_hit   = valid && (pc_exe == instr_pc);
    assign branch_target = instr_pc + {{19{offset[11]}}, offset, 1'b0}; // sext bimm*2

    always_comb begin
        if (taken_hist >= HIST_TAKE_MIN) begin
            branch_prediction = 1'b1;          // strongly taken band
        end else if (taken_hist < HIST_NOT_MIN) begin
            branch_prediction = 1'b0;          // strongly not-taken band
        end else if ((taken_hist ^ pred_hist) >= HIST_ACC_LIMIT) begin
            branch_prediction = ~pred_hist[9]; // recent guesses poor, flip
        end else begin
            branch_prediction = pred_hist[9];  // keep last guess
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid      <= 1'b0;
            taken_hist <= '0;
            pred_hist  <= '0;
        end else if (update_pc) begin
            valid      <= 1'b1;
            taken_hist <= HIST_RESET;
            pred_hist  <= '0;
        end else if (update_history) begin
            taken_hist <= {taken, taken_hist[9:1]};
            pred_hist  <= {predicted, pred_hist[9:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (update_pc) begin
            instr_pc <= pc_exe;
            offset   <= target_offset;
        end
    end

endmodule : btb_entry

/* rtl/jtb_entry.sv */
`timescale 1ns/10ps

module jtb_entry (
    input  logic             clk,
    input  logic             rst,
    input  logic             update_pc,   // allocate on a jal miss
    input  bp_pkg::rv32i_word pc_exe,
    input  bp_pkg::rv32i_word pc_fetch,
    input  bp_pkg::rv32i_word target,
    output logic             fetch_hit,
    output logic             exe_hit,
    output bp_pkg::rv32i_word jump_target
);
    import bp_pkg::*;

    logic      valid;
    rv32i_word instr_pc;
    rv32i_word target_pc;   // jal destination, fixed per pc

    assign fetch_hit   = valid && (pc_fetch == instr_pc);
    assign exe_hit     = valid && (pc_exe == instr_pc);
    assign jump_target = target_pc;

    always_ff @(posedge clk) begin
        if (rst) valid <= 1'b0;
        else if (update_pc) valid <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (update_pc) begin
            instr_pc  <= pc_exe;
            target_pc <= target;
        end
    end

endmodule : jtb_entry

/* rtl/control_buffer.sv */
`timescale 1ns/10ps

module control_buffer #(
    parameter int BTB_ENTRIES = 8,
    parameter int JTB_ENTRIES = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                upd_sel,     // one resolved instr this cycle
    input  bp_pkg::exe_info_t   upd_info,
    input  bp_pkg::rv32i_word    pc_fetch,
    output bp_pkg::fetch_pred_t fetch_pred
);
    import bp_pkg::*;

    localparam int BTB_W = $clog2(BTB_ENTRIES);
    localparam int JTB_W = $clog2(JTB_ENTRIES);

    logic [BTB_ENTRIES-1:0] br_fetch_hits, br_exe_hits;
    logic [BTB_ENTRIES-1:0] br_predictions;
    logic [BTB_ENTRIES-1:0] br_alloc, br_hist_upd;   // per-entry write enables
    logic [JTB_ENTRIES-1:0] jp_fetch_hits, jp_exe_hits;
    logic [JTB_ENTRIES-1:0] jp_alloc;
    rv32i_word              br_targets [BTB_ENTRIES];
    rv32i_word              jp_targets [JTB_ENTRIES];

    logic [BTB_W-1:0] btb_head, br_fetch_idx, br_exe_idx;   // head is oldest entry
    logic [JTB_W-1:0] jtb_head, jp_fetch_idx;

    for (genvar i = 0; i < BTB_ENTRIES; i++) begin : g_btb
        btb_entry u_entry (
            .clk               (clk),
            .rst               (rst),
            .update_pc         (br_alloc[i]),
            .update_history    (br_hist_upd[i]),
            .taken             (upd_info.taken),
            .predicted         (upd_info.predicted),
            .pc_exe            (upd_info.pc),
            .pc_fetch          (pc_fetch),
            .target_offset     (upd_info.bimm),
            .fetch_hit         (br_fetch_hits[i]),
            .exe_hit           (br_exe_hits[i]),
            .branch_prediction (br_predictions[i]),
            .branch_target     (br_targets[i])
        );
    end

    for (genvar j = 0; j < JTB_ENTRIES; j++) begin : g_jtb
        jtb_entry u_entry (
            .clk         (clk),
            .rst         (rst),
            .update_pc   (jp_alloc[j]),
            .pc_exe      (upd_info.pc),
            .pc_fetch    (pc_fetch),
            .target      (upd_info.jump_target),
            .fetch_hit   (jp_fetch_hits[j]),
            .exe_hit     (jp_exe_hits[j]),
            .jump_target (jp_targets[j])
        );
    end

    // one-hot to index, entries never share a pc
    always_comb begin
        br_fetch_idx = '0;
        br_exe_idx   = '0;
        jp_fetch_idx = '0;
        for (int k = 0; k < BTB_ENTRIES; k++) begin
            if (br_fetch_hits[k]) br_fetch_idx = BTB_W'(k);
            if (br_exe_hits[k])   br_exe_idx   = BTB_W'(k);
        end
        for (int k = 0; k < JTB_ENTRIES; k++) begin
            if (jp_fetch_hits[k]) jp_fetch_idx = JTB_W'(k);
        end
    end

    // fetch lookup, branch table first
    always_comb begin
        fetch_pred.prediction = 1'b0;
        fetch_pred.target     = NO_TARGET;
        if (|br_fetch_hits) begin
            fetch_pred.prediction = br_predictions[br_fetch_idx];
            if (br_predictions[br_fetch_idx]) fetch_pred.target = br_targets[br_fetch_idx];
        end else if (|jp_fetch_hits) begin
            fetch_pred.prediction = 1'b1;         // jal always taken
            fetch_pred.target     = jp_targets[jp_fetch_idx];
        end
    end

    // update steering from the resolved instr
    always_comb begin
        br_alloc    = '0;
        br_hist_upd = '0;
        jp_alloc    = '0;
        if (upd_sel) begin
            if (upd_info.opcode == op_br) begin
                if (|br_exe_hits) br_hist_upd[br_exe_idx] = 1'b1;
                else if (upd_info.taken) br_alloc[btb_head] = 1'b1; // only taken enters
            end else if (upd_info.opcode == op_jal) begin
                if (!(|jp_exe_hits) && upd_info.taken) jp_alloc[jtb_head] = 1'b1;
            end
        end
    end

    // fifo heads wrap, sizes are powers of two
    always_ff @(posedge clk) begin
        if (rst) begin
            btb_head <= '0;
            jtb_head <= '0;
        end else begin
            if (|br_alloc) btb_head <= btb_head + 1'b1;
            if (|jp_alloc) jtb_head <= jtb_head + 1'b1;
        end
    end

endmodule : control_buffer

/* rtl/fetch_pc_gen.sv */
`timescale 1ns/10ps

module fetch_pc_gen (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,        // hold the fetch pc
    input  logic                redirect,     // mispredict from execute
    input  bp_pkg::rv32i_word    redirect_pc,
    input  bp_pkg::fetch_pred_t fetch_pred,   // lookup of the current pc
    output bp_pkg::rv32i_word    pc_fetch
);

    // redirect beats stall, stall beats the prediction
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_fetch <= '0;
        end else if (redirect) begin
            pc_fetch <= redirect_pc;
        end else if (!stall) begin
            if (fetch_pred.prediction) pc_fetch <= fetch_pred.target;
            else pc_fetch <= pc_fetch + 32'd4;   // sequential
        end
    end

endmodule : fetch_pc_gen

/* rtl/branch_resolver.sv */
`timescale 1ns/10ps

module branch_resolver (
    input  logic              clk,
    input  logic              rst,
    input  logic              exe_valid,       // first cycle of an instr in execute
    input  bp_pkg::exe_info_t exe_info,
    output logic              upd_sel,         // buffer update strobe
    output bp_pkg::exe_info_t upd_info,
    output logic              redirect,
    output bp_pkg::rv32i_word  redirect_pc,
    output bp_pkg::rv32i_word  br_count,
    output bp_pkg::rv32i_word  mispredict_count
);
    import bp_pkg::*;

    logic      is_br, is_jal, is_ctrl;
    logic      mispredict;
    rv32i_word actual_target;   // where a taken instr goes
    rv32i_word next_pc;         // correct successor

    assign is_br   = (exe_info.opcode == op_br);
    assign is_jal  = (exe_info.opcode == op_jal);
    assign is_ctrl = is_br || is_jal;

    always_comb begin
        if (is_jal) actual_target = exe_info.jump_target;
        else actual_target = exe_info.pc + {{19{exe_info.bimm[11]}}, exe_info.bimm, 1'b0};
    end

    // wrong direction, or right direction with a stale target
    assign mispredict = is_ctrl && ((exe_info.taken != exe_info.predicted)
                        || (exe_info.taken && (exe_info.pred_target != actual_target)));

    assign next_pc = exe_info.taken ? actual_target : exe_info.pc + 32'd4;

    always_ff @(posedge clk) begin
        if (rst) begin
            upd_sel          <= 1'b0;
            redirect         <= 1'b0;
            br_count         <= '0;
            mispredict_count <= '0;
        end else begin
            upd_sel  <= exe_valid;
            redirect <= exe_valid && mispredict;   // one-cycle pulse
            if (exe_valid && is_ctrl) br_count <= br_count + 1'b1;
            if (exe_valid && mispredict) mispredict_count <= mispredict_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (exe_valid) begin
            upd_info    <= exe_info;
            redirect_pc <= next_pc;
        end
    end

endmodule : branch_resolver

/* rtl/bp_frontend_top.sv */
`timescale 1ns/10ps

module bp_frontend_top #(
    parameter int BTB_ENTRIES = 8,   // power of two
    parameter int JTB_ENTRIES = 4    // power of two
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                exe_valid,
    input  bp_pkg::exe_info_t   exe_info,
    input  logic                stall,
    output bp_pkg::rv32i_word    pc_fetch,
    output bp_pkg::fetch_pred_t fetch_pred,
    output logic                redirect,
    output bp_pkg::rv32i_word    redirect_pc,
    output bp_pkg::rv32i_word    br_count,
    output bp_pkg::rv32i_word    mispredict_count
);
    import bp_pkg::*;

    logic      upd_sel;    // registered resolve strobe
    exe_info_t upd_info;   // resolved instr for the buffer

    fetch_pc_gen u_fetch (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fetch_pred  (fetch_pred),
        .pc_fetch    (pc_fetch)
    );

    control_buffer #(
        .BTB_ENTRIES (BTB_ENTRIES),
        .JTB_ENTRIES (JTB_ENTRIES)
    ) u_buffer (
        .clk        (clk),
        .rst        (rst),
        .upd_sel    (upd_sel),
        .upd_info   (upd_info),
        .pc_fetch   (pc_fetch),
        .fetch_pred (fetch_pred)
    );

    branch_resolver u_resolver (
        .clk              (clk),
        .rst              (rst),
        .exe_valid        (exe_valid),
        .exe_info         (exe_info),
        .upd_sel          (upd_sel),
        .upd_info         (upd_info),
        .redirect         (redirect),
        .redirect_pc      (redirect_pc),
        .br_count         (br_count),
        .mispredict_count (mispredict_count)
    );

endmodule : bp_frontend_top

/* include/bp_ref_model.svh */
`ifndef BP_REF_MODEL_SVH
`define BP_REF_MODEL_SVH

// model state sized by the including scope's BTB_ENTRIES and JTB_ENTRIES
bit        ref_br_valid [BTB_ENTRIES];
rv32i_word ref_br_pc    [BTB_ENTRIES];
bimm_t     ref_br_off   [BTB_ENTRIES];
br_hist_t  ref_br_th    [BTB_ENTRIES];   // taken history
br_hist_t  ref_br_ph    [BTB_ENTRIES];   // prediction history
int        ref_br_head;
bit        ref_jp_valid [JTB_ENTRIES];
rv32i_word ref_jp_pc    [JTB_ENTRIES];
rv32i_word ref_jp_tgt   [JTB_ENTRIES];
int        ref_jp_head;
rv32i_word ref_br_count;
rv32i_word ref_mis_count;

function automatic void clear_model();
    foreach (ref_br_valid[i]) ref_br_valid[i] = 1'b0;
    foreach (ref_jp_valid[i]) ref_jp_valid[i] = 1'b0;
    ref_br_head   = 0;
    ref_jp_head   = 0;
    ref_br_count  = '0;
    ref_mis_count = '0;
endfunction

function automatic logic hist_predict(br_hist_t th, br_hist_t ph);
    if (th >= HIST_TAKE_MIN) return 1'b1;
    if (th < HIST_NOT_MIN) return 1'b0;
    if ((th ^ ph) >= HIST_ACC_LIMIT) return ~ph[9];
    return ph[9];
endfunction

function automatic rv32i_word offset_target(rv32i_word pc, bimm_t off);
    int disp;
    disp = $signed(off) * 2;   // imm[12:1] as a signed byte offset
    return pc + rv32i_word'(disp);
endfunction

function automatic fetch_pred_t ref_lookup(rv32i_word pc);
    fetch_pred_t p;
    p.prediction = 1'b0;
    p.target     = NO_TARGET;
    foreach (ref_br_valid[i]) begin
        if (ref_br_valid[i] && ref_br_pc[i] == pc) begin
            p.prediction = hist_predict(ref_br_th[i], ref_br_ph[i]);
            if (p.prediction) p.target = offset_target(pc, ref_br_off[i]);
            return p;
        end
    end
    foreach (ref_jp_valid[i]) begin
        if (ref_jp_valid[i] && ref_jp_pc[i] == pc) begin
            p.prediction = 1'b1;
            p.target     = ref_jp_tgt[i];
        end
    end
    return p;
endfunction

function automatic void ref_resolve(exe_info_t e, output logic redir, output rv32i_word rpc);
    rv32i_word tgt;
    logic      ctrl;
    ctrl  = (e.opcode == op_br) || (e.opcode == op_jal);
    tgt   = (e.opcode == op_jal) ? e.jump_target : offset_target(e.pc, e.bimm);
    redir = ctrl && ((e.taken != e.predicted) || (e.taken && e.pred_target != tgt));
    rpc   = e.taken ? tgt : e.pc + 32'd4;
endfunction

function automatic void ref_update(exe_info_t e);
    logic      redir;
    rv32i_word rpc;
    bit        hit;
    ref_resolve(e, redir, rpc);
    hit = 1'b0;
    if (e.opcode == op_br || e.opcode == op_jal) ref_br_count++;
    if (redir) ref_mis_count++;
    if (e.opcode == op_br) begin
        foreach (ref_br_valid[i]) begin
            if (ref_br_valid[i] && ref_br_pc[i] == e.pc) begin
                hit          = 1'b1;
                ref_br_th[i] = {e.taken, ref_br_th[i][9:1]};
                ref_br_ph[i] = {e.predicted, ref_br_ph[i][9:1]};
            end
        end
        if (!hit && e.taken) begin
            ref_br_valid[ref_br_head] = 1'b1;
            ref_br_pc[ref_br_head]    = e.pc;
            ref_br_off[ref_br_head]   = e.bimm;
            ref_br_th[ref_br_head]    = HIST_RESET;
            ref_br_ph[ref_br_head]    = '0;
            ref_br_head               = (ref_br_head + 1) % BTB_ENTRIES;
        end
    end else if (e.opcode == op_jal) begin
        foreach (ref_jp_valid[i]) hit |= ref_jp_valid[i] && ref_jp_pc[i] == e.pc;
        if (!hit && e.taken) begin
            ref_jp_valid[ref_jp_head] = 1'b1;
            ref_jp_pc[ref_jp_head]    = e.pc;
            ref_jp_tgt[ref_jp_head]   = e.jump_target;
            ref_jp_head               = (ref_jp_head + 1) % JTB_ENTRIES;
        end
    end
endfunction

`endif

/* bench/tb_bp_frontend.sv */
`timescale 1ns/10ps

module tb_bp_frontend;
    import bp_pkg::*;

    localparam int BTB_ENTRIES  = 8;
    localparam int JTB_ENTRIES  = 4;
    localparam int CLK_PERIOD   = 8;     // ns
    localparam int RESET_CYCLES = 8;
    localparam int N_DIRECTED   = 46;    // instrs issued by the directed phases
    localparam int N_RAND       = 150;
    localparam int WATCHDOG_CYCLES = (N_DIRECTED + N_RAND) * 20 + RESET_CYCLES;

    `include "bp_ref_model.svh"

    logic        clk;
    logic        rst;
    logic        exe_valid;
    exe_info_t   exe_info;
    logic        stall;
    rv32i_word   pc_fetch;
    fetch_pred_t fetch_pred;
    logic        redirect;
    rv32i_word   redirect_pc;
    rv32i_word   br_count;
    rv32i_word   mispredict_count;

    int        seed = 32'h7955_39f4;
    rv32i_word steer_pc = 32'h1000;   // fresh jal pcs that always miss
    rv32i_word exp_pc;                // expected pc_fetch this cycle
    logic      exp_redir;
    rv32i_word exp_rpc;
    logic      pend_valid;            // strobe of the previous cycle
    exe_info_t pend_info;

    bp_frontend_top #(
        .BTB_ENTRIES (BTB_ENTRIES),
        .JTB_ENTRIES (JTB_ENTRIES)
    ) DUT (
        .clk              (clk),
        .rst              (rst),
        .exe_valid        (exe_valid),
        .exe_info         (exe_info),
        .stall            (stall),
        .pc_fetch         (pc_fetch),
        .fetch_pred       (fetch_pred),
        .redirect         (redirect),
        .redirect_pc      (redirect_pc),
        .br_count         (br_count),
        .mispredict_count (mispredict_count)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_mismatch(string msg);
        $display("mismatch at %0t ns: %s", $time, msg);
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_pred(fetch_pred_t got, fetch_pred_t exp);
        if (got !== exp)
            report_mismatch($sformatf("fetch_pred at pc %h: got %b/%h, expected %b/%h",
                exp_pc, got.prediction, got.target, exp.prediction, exp.target));
    endtask

    task automatic compare_redirect(logic got, rv32i_word got_pc, logic exp, rv32i_word exp_pc);
        if (got !== exp || (exp && got_pc !== exp_pc))   // pc only matters on a pulse
            report_mismatch($sformatf("redirect: got %b/%h, expected %b/%h",
                got, got_pc, exp, exp_pc));
    endtask

    task automatic compare_count(rv32i_word got, rv32i_word exp, string what);
        if (got !== exp)
            report_mismatch($sformatf("%s: got %h, expected %h", what, got, exp));
    endtask

    // one strobe carrying the model's lookup of that pc
    task automatic issue(rv32i_opcode op, rv32i_word pc, logic taken, rv32i_word jt, bimm_t b);
        exe_info_t   e;
        fetch_pred_t p;
        @(posedge clk);
        p = ref_lookup(pc);
        e.pc          = pc;
        e.opcode      = op;
        e.taken       = taken;
        e.jump_target = jt;
        e.bimm        = b;
        e.predicted   = p.prediction;
        e.pred_target = p.target;
        exe_valid <= 1'b1;
        exe_info  <= e;
    endtask

    task automatic idle(int n, logic st);
        repeat (n) begin
            @(posedge clk);
            exe_valid <= 1'b0;
            stall     <= st;
        end
    endtask

    // unpredicted jal forces fetch onto tgt two cycles later
    task automatic steer_to(rv32i_word tgt);
        issue(op_jal, steer_pc, 1'b1, tgt, '0);
        steer_pc = steer_pc + 32'd4;
    endtask

    task automatic probe_br(logic taken);
        issue(op_br, 32'h200, taken, '0, 12'h010);   // target 0x220
        steer_to(32'h200);
        idle(2, 1'b1);                               // hold fetch on the branch
    endtask

    task automatic run_random(int n);
        rv32i_word pc;
        int        kind;
        repeat (n) begin
            pc   = 32'h40 + 32'(($random(seed) & 7) * 4);   // small pool so entries get evicted
            kind = $random(seed) & 3;
            if (kind < 2)
                issue(op_br, pc, 1'($random(seed)), '0, bimm_t'((pc >> 1) & 12'h00e) - 12'd6);
            else if (kind == 2)
                issue(op_jal, pc, 1'b1, 32'h40 + (((pc >> 2) * 3) & 7) * 4, '0);
            else
                issue(op_imm, pc, 1'b0, '0, '0);
            if ($random(seed) & 1) idle(1, ($random(seed) & 7) == 0);
        end
    endtask

    // expected state steps at negedge once inputs and outputs have settled
    always @(negedge clk) begin : check_cycle
        fetch_pred_t exp_pred;
        if (rst) begin
            clear_model();
            exp_pc     = '0;
            exp_redir  = 1'b0;
            pend_valid = 1'b0;
        end else begin
            exp_pred = ref_lookup(exp_pc);   // table as written up to last edge
            compare_count(pc_fetch, exp_pc, "pc_fetch");
            compare_pred(fetch_pred, exp_pred);
            compare_redirect(redirect, redirect_pc, exp_redir, exp_rpc);
            if (pend_valid) ref_update(pend_info);   // written at the coming edge
            compare_count(br_count, ref_br_count, "br_count");
            compare_count(mispredict_count, ref_mis_count, "mispredict_count");
            if (exp_redir) exp_pc = exp_rpc;
            else if (!stall) exp_pc = exp_pred.prediction ? exp_pred.target : exp_pc + 32'd4;
            exp_redir = 1'b0;
            if (exe_valid) ref_resolve(exe_info, exp_redir, exp_rpc);
            pend_valid = exe_valid;
            pend_info  = exe_info;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish in %0d cycles", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        clk       = 1'b0;
        rst       = 1'b1;
        exe_valid = 1'b0;
        exe_info  = '0;
        stall     = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        idle(12, 1'b0);   // empty tables give sequential fetch
        idle(4, 1'b1);
        idle(4, 1'b0);
        // walk one branch through all three bands
        for (int i = 0; i < 14; i++) probe_br((i < 4) || (i == 11) || (i == 13));
        idle(1, 1'b0);
        issue(op_jal, 32'h300, 1'b1, 32'h240, '0);   // jal allocation
        idle(2, 1'b0);
        steer_to(32'h300);                         // fetch then follows 0x240
        idle(4, 1'b0);
        for (int k = 0; k <= BTB_ENTRIES; k++) issue(op_br, 32'h400 + 8 * k, 1'b1, '0, 12'h004);
        idle(2, 1'b0);
        steer_to(32'h400);   // oldest branch now evicted
        idle(3, 1'b0);
        for (int k = 0; k <= JTB_ENTRIES; k++) issue(op_jal, 32'h500 + 4 * k, 1'b1, 32'h600, '0);
        idle(2, 1'b0);
        steer_to(32'h500);
        idle(3, 1'b0);
        run_random(N_RAND);
        idle(4, 1'b0);
        $display("** PASS **");
        $finish;
    end

endmodule : tb_bp_frontend

/* list.f */
+incdir+include
rtl/bp_pkg.sv
rtl/btb_entry.sv
rtl/jtb_entry.sv
rtl/control_buffer.sv
rtl/fetch_pc_gen.sv
rtl/branch_resolver.sv
rtl/bp_frontend_top.sv
bench/tb_bp_frontend.sv
